// ==== Bender.yml ====
package:
  name: etx

sources:
  - design/etx_pkg.sv
  - design/etx_packet_in.sv
  - design/etx_protocol.sv
  - design/etx_lane_out.sv
  - design/etx_top.sv
  - target: simulation
    files:
      - verification/etx_tb.sv

// ==== design/etx_lane_out.sv ====
//####################
// Shifts 64-bit link words out as bytes, MSB first
// One idle cycle between words while word_ready is high
// lane_wait freezes byte, frame and counter
//####################
`timescale 1ns/1ps
`default_nettype none

module etx_lane_out
   import etx_pkg::*;
(
   input  wire               clk,
   input  wire               nreset,
   // Word side
   input  wire               word_valid,
   input  wire [WORD_W-1:0]  word_data,
   input  wire               word_frame,
   output logic              word_ready,
   // Lane side
   input  wire               lane_wait,
   output logic              lane_valid,
   output logic [7:0]        lane_data,
   output logic              lane_frame
);

   lane_state_t           state;
   logic [WORD_W-1:0]     shift_reg;   // Current byte sits in the top
   logic [BYTE_CNT_W-1:0] byte_cnt;
   logic                  frame_reg;   // Copy of word_frame
   logic                  word_xfer;
   logic                  byte_done;   // Byte counted this cycle
   logic                  hdr_mark;

   assign word_ready = (state == LANE_IDLE);
   assign word_xfer  = word_valid & word_ready;
   assign byte_done  = (state == LANE_SHIFT) & ~lane_wait;

   //####################
   // Byte sequencer
   //####################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         state    <= LANE_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state)
            LANE_IDLE: begin
               if (word_xfer) begin
                  state    <= LANE_SHIFT;
                  byte_cnt <= '0;
               end
            end
            default: begin
               if (byte_done) begin
                  if (byte_cnt == LAST_BYTE) begin
                     state <= LANE_IDLE;   // Ready again next cycle
                  end
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // Shift register and frame copy
   always_ff @(posedge clk) begin
      if (word_xfer) begin
         shift_reg <= word_data;
         frame_reg <= word_frame;
      end else if (byte_done) begin
         shift_reg <= {shift_reg[WORD_W-9:0], 8'h00};  // Next byte up
      end
   end

   //####################
   // Lane outputs
   //####################
   // First two header bytes carry frame low
   assign hdr_mark   = ~frame_reg & (byte_cnt < HDR_MARK_BYTES);

   assign lane_valid = (state == LANE_SHIFT);
   assign lane_data  = shift_reg[WORD_W-1 -: 8];
   assign lane_frame = lane_valid & ~hdr_mark;

endmodule

`default_nettype wire

// ==== design/etx_packet_in.sv ====
//####################
// Four-phase req/ack capture into a one-entry holding register
// Packet must stay stable while req is high
// ack is withheld while the register is full
//####################
`timescale 1ns/1ps
`default_nettype none

module etx_packet_in
   import etx_pkg::*;
(
   input  wire                clk,
   input  wire                nreset,
   // System side
   input  wire                req,
   input  wire [PKT_W-1:0]    packet,
   output logic               ack,
   // Decoded view of the held packet
   output logic               pkt_valid,
   output logic               pkt_write,
   output logic [DMODE_W-1:0] pkt_datamode,
   output logic [CMODE_W-1:0] pkt_ctrlmode,
   output logic [ADDR_W-1:0]  pkt_dstaddr,
   output logic [DATA_W-1:0]  pkt_data,
   output logic [ADDR_W-1:0]  pkt_srcaddr,
   input  wire                pkt_take
);

   logic             full;      // Holding register occupied
   logic [PKT_W-1:0] hold_pkt;  // Held packet
   logic             capture;

   // New request, previous one closed and room to store it
   assign capture = req & ~ack & ~full;

   //####################
   // Handshake and occupancy
   //####################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         ack  <= 1'b0;
         full <= 1'b0;
      end else begin
         if (capture) begin
            ack <= 1'b1;
         end else if (ack && !req) begin
            ack <= 1'b0;            // Return to zero phase
         end

         if (capture) begin
            full <= 1'b1;
         end else if (pkt_take) begin
            full <= 1'b0;           // Protocol consumed it
         end
      end
   end

   // Held packet, loaded on capture
   always_ff @(posedge clk) begin
      if (capture) begin
         hold_pkt <= packet;
      end
   end

   //####################
   // Field decode
   //####################
   assign pkt_valid    = full;
   assign pkt_write    = hold_pkt[PKT_WRITE_BIT];
   assign pkt_datamode = hold_pkt[PKT_DMODE_LSB +: DMODE_W];
   assign pkt_ctrlmode = hold_pkt[PKT_CMODE_LSB +: CMODE_W];
   assign pkt_dstaddr  = hold_pkt[PKT_DST_LSB +: ADDR_W];
   assign pkt_data     = hold_pkt[PKT_DATA_LSB +: DATA_W];
   assign pkt_srcaddr  = hold_pkt[PKT_SRC_LSB +: ADDR_W];

endmodule

`default_nettype wire

// ==== design/etx_pkg.sv ====
//####################
// Link format constants and FSM state types for the transmit path
// Packet is fixed at 104 bits and field positions are not configurable
// Only ctrlmode[3:0] reaches the header, bit 4 stays internal
//####################
`default_nettype none

package etx_pkg;

   //####################
   // Packet fields
   //####################
   localparam int PKT_W         = 104;
   localparam int DMODE_W       = 2;
   localparam int CMODE_W       = 5;
   localparam int ADDR_W        = 32;
   localparam int DATA_W        = 32;

   localparam int PKT_WRITE_BIT = 0;    // Write flag
   localparam int PKT_DMODE_LSB = 1;    // 2:1
   localparam int PKT_CMODE_LSB = 3;    // 7:3
   localparam int PKT_DST_LSB   = 8;    // 39:8
   localparam int PKT_DATA_LSB  = 40;   // 71:40
   localparam int PKT_SRC_LSB   = 72;   // 103:72

   localparam logic [DMODE_W-1:0] DMODE_DOUBLE = 2'b11;
   localparam logic [ADDR_W-1:0]  BURST_STRIDE = 32'd8; // Next beat address step

   //####################
   // Link word layout
   //####################
   localparam int WORD_W       = 64;
   localparam int HDR_CTRL_LSB = 40;    // Control byte 47:40
   localparam int HDR_DST_LSB  = 8;     // dstaddr 39:8

   // Lane byte counting, MSB first
   localparam int             BYTE_CNT_W     = 3;
   localparam logic [BYTE_CNT_W-1:0] LAST_BYTE      = 3'd7;
   localparam logic [BYTE_CNT_W-1:0] HDR_MARK_BYTES = 3'd2; // Bytes framed low

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_HEAD,     // Header word offered
      TX_BODY,     // Payload word offered
      TX_BURST     // Burst payload offered, no header
   } tx_state_t;

   typedef enum logic {
      LANE_IDLE,
      LANE_SHIFT
   } lane_state_t;

endpackage

`default_nettype wire

// ==== design/etx_protocol.sv ====
//####################
// Transmit FSM, ctrlmode override, burst detect and word format
// Holds one packet while the next waits in the input register
// Burst needs double writes, ctrlmode zero and address step of 8
//####################
`timescale 1ns/1ps
`default_nettype none

module etx_protocol
   import etx_pkg::*;
(
   input  wire                clk,
   input  wire                nreset,
   // Config
   input  wire                tx_enable,
   input  wire                burst_enable,
   input  wire                ctrlmode_bypass,
   input  wire [3:0]          ctrlmode,
   // Waiting packet from input side
   input  wire                pkt_valid,
   input  wire                pkt_write,
   input  wire [DMODE_W-1:0]  pkt_datamode,
   input  wire [CMODE_W-1:0]  pkt_ctrlmode,
   input  wire [ADDR_W-1:0]   pkt_dstaddr,
   input  wire [DATA_W-1:0]   pkt_data,
   input  wire [ADDR_W-1:0]   pkt_srcaddr,
   output logic               pkt_take,
   // Word stream to lane output
   output logic               word_valid,
   output logic [WORD_W-1:0]  word_data,
   output logic               word_frame,
   input  wire                word_ready,
   // Status
   output logic               tx_burst,
   output logic               tx_busy
);

   tx_state_t state;
   tx_state_t state_nxt;

   // Current packet, override already applied
   logic               cur_write;
   logic [DMODE_W-1:0] cur_datamode;
   logic [CMODE_W-1:0] cur_ctrlmode;
   logic [ADDR_W-1:0]  cur_dstaddr;
   logic [DATA_W-1:0]  cur_data;
   logic [ADDR_W-1:0]  cur_srcaddr;

   logic [CMODE_W-1:0] eff_ctrlmode;  // Waiting packet after override
   logic               word_xfer;
   logic               new_ok;
   logic               cur_match;
   logic               next_match;
   logic               addr_match;
   logic               burst_hit;
   logic [WORD_W-1:0]  hdr_word;
   logic [WORD_W-1:0]  pay_word;

   //####################
   // Control-mode override
   //####################
   // Bit 4 is never replaced
   assign eff_ctrlmode = ctrlmode_bypass ? {pkt_ctrlmode[CMODE_W-1], ctrlmode} :
                                           pkt_ctrlmode;

   always_ff @(posedge clk) begin
      if (pkt_take) begin
         cur_write    <= pkt_write;
         cur_datamode <= pkt_datamode;
         cur_ctrlmode <= eff_ctrlmode;
         cur_dstaddr  <= pkt_dstaddr;
         cur_data     <= pkt_data;
         cur_srcaddr  <= pkt_srcaddr;
      end
   end

   //####################
   // Burst detection
   //####################
   assign cur_match  = cur_write &
                       (cur_datamode == DMODE_DOUBLE) &
                       (cur_ctrlmode == '0);

   assign next_match = pkt_valid &
                       pkt_write &
                       (pkt_datamode == DMODE_DOUBLE) &
                       (eff_ctrlmode == '0);

   assign addr_match = ((cur_dstaddr + BURST_STRIDE) == pkt_dstaddr);

   assign burst_hit  = burst_enable & cur_match & next_match & addr_match;

   //####################
   // Transmit FSM
   //####################
   assign word_xfer = word_valid & word_ready;
   assign new_ok    = pkt_valid & tx_enable;    // Enable gates new traffic

   always_comb begin
      state_nxt = state;
      pkt_take  = 1'b0;
      case (state)
         TX_IDLE: begin
            if (new_ok) begin
               pkt_take  = 1'b1;
               state_nxt = TX_HEAD;
            end
         end
         TX_HEAD: begin
            if (word_xfer) begin
               state_nxt = TX_BODY;
            end
         end
         default: begin                         // TX_BODY or TX_BURST
            if (word_xfer) begin
               if (tx_enable && burst_hit) begin
                  pkt_take  = 1'b1;
                  state_nxt = TX_BURST;         // Payload only
               end else if (new_ok) begin
                  pkt_take  = 1'b1;
                  state_nxt = TX_HEAD;
               end else begin
                  state_nxt = TX_IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!nreset) begin
         state <= TX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   //####################
   // Word formatting
   //####################
   always_comb begin
      hdr_word = '0;                            // Top two bytes are the start marker
      hdr_word[HDR_CTRL_LSB +: 8] = {cur_write, cur_datamode, cur_ctrlmode[3:0], 1'b0};
      hdr_word[HDR_DST_LSB +: ADDR_W] = cur_dstaddr;
   end

   assign pay_word = {cur_data, cur_srcaddr};

   assign word_valid = (state != TX_IDLE);
   assign word_frame = (state != TX_HEAD);      // 0 marks a header word
   assign word_data  = (state == TX_HEAD) ? hdr_word : pay_word;

   assign tx_burst = (state == TX_BURST);
   assign tx_busy  = (state != TX_IDLE);

endmodule

`default_nettype wire

// ==== design/etx_top.sv ====
//####################
// Transmit link top, input side to protocol to lane output
// One lane_wait back-pressures all traffic
//####################
`timescale 1ns/1ps
`default_nettype none

module etx_top
   import etx_pkg::*;
(
   input  wire              clk,
   input  wire              nreset,
   // System packet port
   input  wire              req,
   input  wire [PKT_W-1:0]  packet,
   output logic             ack,
   // Config
   input  wire              tx_enable,
   input  wire              burst_enable,
   input  wire              ctrlmode_bypass,
   input  wire [3:0]        ctrlmode,
   // Lane
   input  wire              lane_wait,
   output logic             lane_valid,
   output logic [7:0]       lane_data,
   output logic             lane_frame,
   // Status
   output logic             tx_burst,
   output logic             tx_busy
);

   // Holding register to protocol
   logic               pkt_valid;
   logic               pkt_write;
   logic [DMODE_W-1:0] pkt_datamode;
   logic [CMODE_W-1:0] pkt_ctrlmode;
   logic [ADDR_W-1:0]  pkt_dstaddr;
   logic [DATA_W-1:0]  pkt_data;
   logic [ADDR_W-1:0]  pkt_srcaddr;
   logic               pkt_take;

   // Protocol to lane output
   logic               word_valid;
   logic [WORD_W-1:0]  word_data;
   logic               word_frame;
   logic               word_ready;

   etx_packet_in u_packet_in (
      .clk          (clk),
      .nreset       (nreset),
      .req          (req),
      .packet       (packet),
      .ack          (ack),
      .pkt_valid    (pkt_valid),
      .pkt_write    (pkt_write),
      .pkt_datamode (pkt_datamode),
      .pkt_ctrlmode (pkt_ctrlmode),
      .pkt_dstaddr  (pkt_dstaddr),
      .pkt_data     (pkt_data),
      .pkt_srcaddr  (pkt_srcaddr),
      .pkt_take     (pkt_take)
   );

   etx_protocol u_protocol (
      .clk             (clk),
      .nreset          (nreset),
      .tx_enable       (tx_enable),
      .burst_enable    (burst_enable),
      .ctrlmode_bypass (ctrlmode_bypass),
      .ctrlmode        (ctrlmode),
      .pkt_valid       (pkt_valid),
      .pkt_write       (pkt_write),
      .pkt_datamode    (pkt_datamode),
      .pkt_ctrlmode    (pkt_ctrlmode),
      .pkt_dstaddr     (pkt_dstaddr),
      .pkt_data        (pkt_data),
      .pkt_srcaddr     (pkt_srcaddr),
      .pkt_take        (pkt_take),
      .word_valid      (word_valid),
      .word_data       (word_data),
      .word_frame      (word_frame),
      .word_ready      (word_ready),
      .tx_burst        (tx_burst),
      .tx_busy         (tx_busy)
   );

   etx_lane_out u_lane_out (
      .clk        (clk),
      .nreset     (nreset),
      .word_valid (word_valid),
      .word_data  (word_data),
      .word_frame (word_frame),
      .word_ready (word_ready),
      .lane_wait  (lane_wait),
      .lane_valid (lane_valid),
      .lane_data  (lane_data),
      .lane_frame (lane_frame)
   );

endmodule

`default_nettype wire

// ==== project.f ====
design/etx_pkg.sv
design/etx_packet_in.sv
design/etx_protocol.sv
design/etx_lane_out.sv
design/etx_top.sv
verification/etx_tb.sv

// ==== verification/etx_tb.sv ====
//####################
// Testbench for the transmit link top
// Model assumes the driver keeps the next packet waiting within a test
// Lane wait pattern is drawn once per test into a 256-entry table
//####################
`timescale 1ns/1ps
`default_nettype none

module etx_tb
   import etx_pkg::*;
();

   localparam int HS_TIMEOUT    = 300;   // Cycles per handshake phase
   localparam int DRAIN_TIMEOUT = 4000;

   logic             clk;
   logic             nreset;
   logic             req;
   logic [PKT_W-1:0] packet;
   logic             ack;
   logic             tx_enable;
   logic             burst_enable;
   logic             ctrlmode_bypass;
   logic [3:0]       ctrlmode;
   logic             lane_wait;
   logic             lane_valid;
   logic [7:0]       lane_data;
   logic             lane_frame;
   logic             tx_burst;
   logic             tx_busy;

   integer      seed;
   int          err_cnt;
   int          test_err_start;
   int          tests_pass;
   int          tests_fail;
   string       test_name;
   logic [64:0] exp_q[$];        // {is_header, word}
   logic [64:0] exp_head;
   logic        wait_pat [256];
   logic [7:0]  cyc;
   logic        wait_rand;       // Lane wait from table
   logic        hold_gate;       // Window with tx_enable low
   logic        burst_seen;

   // Model history, previous packet of this test
   logic        prev_valid;
   logic        prev_write;
   logic [1:0]  prev_dmode;
   logic [4:0]  prev_cm;
   logic [31:0] prev_dst;

   // Lane decoder state
   logic [2:0]  byte_idx;
   logic [55:0] acc;
   logic [6:0]  frame_acc;       // Frames of bytes so far, byte 0 on top
   logic        word_done;       // One-cycle pulse per decoded word
   logic [63:0] dec_word;
   logic [7:0]  dec_frames;
   logic        dec_hdr;
   logic [63:0] exp_word;
   logic [7:0]  exp_frames;
   logic        exp_hdr;
   logic        exp_ok;          // Queue had an entry

   etx_top u_etx_top (
      .clk(clk), .nreset(nreset), .req(req), .packet(packet), .ack(ack),
      .tx_enable(tx_enable), .burst_enable(burst_enable),
      .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode),
      .lane_wait(lane_wait), .lane_valid(lane_valid), .lane_data(lane_data),
      .lane_frame(lane_frame), .tx_burst(tx_burst), .tx_busy(tx_busy)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                  // 4 ns period
   end

   //####################
   // Lane side
   //####################
   always @(posedge clk) begin
      lane_wait <= wait_rand ? wait_pat[cyc] : 1'b0;
      cyc       <= cyc + 1'b1;
      if (tx_burst) burst_seen <= 1'b1;
   end

   // Bytes collected MSB first, frame of byte 0 tags the word
   always @(posedge clk) begin
      word_done <= 1'b0;
      if (!nreset) begin
         byte_idx <= '0;
      end else if (lane_valid && !lane_wait) begin
         acc       <= {acc[47:0], lane_data};
         frame_acc <= {frame_acc[5:0], lane_frame};
         if (byte_idx == 3'd7) begin
            dec_word   <= {acc, lane_data};
            dec_frames <= {frame_acc, lane_frame};
            dec_hdr    <= !frame_acc[6];     // Start marker framed low
            word_done  <= 1'b1;
            exp_ok     <= (exp_q.size() > 0);
            if (exp_q.size() > 0) begin
               exp_head = exp_q.pop_front();
               exp_hdr    <= exp_head[64];
               exp_word   <= exp_head[63:0];
               exp_frames <= exp_head[64] ? 8'h3f : 8'hff;  // Header leads with two low
            end
         end
         byte_idx <= byte_idx + 1'b1;
      end
   end

   //####################
   // Assertions
   //####################
   word_check: assert property (@(posedge clk) disable iff (!nreset)
      word_done |-> (exp_ok && dec_hdr == exp_hdr && dec_word == exp_word &&
                     dec_frames == exp_frames))
   else begin
      err_cnt++;
      if (!exp_ok)
         $display("Unexpected word %h on the lane in test %s", dec_word, test_name);
      else
         $display("FAIL %s: expected %s %h frames %b, actual %s %h frames %b", test_name,
                  exp_hdr ? "header" : "payload", exp_word, exp_frames,
                  dec_hdr ? "header" : "payload", dec_word, dec_frames);
   end

   hold_check: assert property (@(posedge clk) disable iff (!nreset)
      (lane_valid && lane_wait) |=> (lane_valid && $stable(lane_data) && $stable(lane_frame)))
   else begin
      err_cnt++;
      $display("Lane byte or frame changed under lane_wait in test %s", test_name);
   end

   ack_rise_check: assert property (@(posedge clk) disable iff (!nreset)
      $rose(ack) |-> $past(req))
   else begin
      err_cnt++;
      $display("ack rose while req was low in test %s", test_name);
   end

   ack_fall_check: assert property (@(posedge clk) disable iff (!nreset)
      $fell(ack) |-> !$past(req))
   else begin
      err_cnt++;
      $display("ack fell while req was high in test %s", test_name);
   end

   // Outputs low in the cycle after each reset cycle
   reset_check: assert property (@(posedge clk)
      !nreset |=> (ack === 1'b0 && lane_valid === 1'b0 && lane_frame === 1'b0 &&
                   tx_burst === 1'b0 && tx_busy === 1'b0))
   else begin
      err_cnt++;
      $display("Outputs not low during or right after reset");
   end

   gate_check: assert property (@(posedge clk) disable iff (!nreset)
      hold_gate |-> (!lane_valid && !ack))
   else begin
      err_cnt++;
      $display("Traffic moved while tx_enable was low in test %s", test_name);
   end

   //####################
   // Model and driver
   //####################
   function automatic logic [PKT_W-1:0] make_packet(input logic w, input logic [1:0] dm,
                                                    input logic [4:0] cm,
                                                    input logic [31:0] dst);
      logic [PKT_W-1:0] p;
      p = '0;
      p[PKT_WRITE_BIT]        = w;
      p[PKT_DMODE_LSB +: 2]   = dm;
      p[PKT_CMODE_LSB +: 5]   = cm;
      p[PKT_DST_LSB +: 32]    = dst;
      p[PKT_DATA_LSB +: 32]   = $random(seed);
      p[PKT_SRC_LSB +: 32]    = $random(seed);
      return p;
   endfunction

   // Random write flag, modes and address
   function automatic logic [PKT_W-1:0] random_packet();
      logic [31:0] r;
      logic [31:0] dst;
      r   = $random(seed);
      dst = $random(seed);
      return make_packet(r[0], r[2:1], r[7:3], dst);
   endfunction

   function automatic void expect_packet(input logic [PKT_W-1:0] p);
      logic        w;
      logic [1:0]  dm;
      logic [4:0]  cm;
      logic [31:0] dst;
      logic [63:0] hdr;
      logic        cont;
      w   = p[PKT_WRITE_BIT];
      dm  = p[PKT_DMODE_LSB +: 2];
      dst = p[PKT_DST_LSB +: 32];
      cm  = ctrlmode_bypass ? {p[PKT_CMODE_LSB + 4], ctrlmode} : p[PKT_CMODE_LSB +: 5];
      cont = burst_enable && prev_valid && prev_write && prev_dmode == DMODE_DOUBLE &&
             prev_cm == 5'd0 && w && dm == DMODE_DOUBLE && cm == 5'd0 &&
             dst == prev_dst + BURST_STRIDE;
      if (!cont) begin
         hdr = '0;                             // Top two bytes stay zero
         hdr[47]    = w;
         hdr[46:45] = dm;
         hdr[44:41] = cm[3:0];
         hdr[39:8]  = dst;
         exp_q.push_back({1'b1, hdr});
      end
      exp_q.push_back({1'b0, p[PKT_DATA_LSB +: 32], p[PKT_SRC_LSB +: 32]});
      prev_valid = 1'b1;
      prev_write = w;
      prev_dmode = dm;
      prev_cm    = cm;
      prev_dst   = dst;
   endfunction

   task automatic send_packet(input logic [PKT_W-1:0] p);
      int n;
      expect_packet(p);
      @(posedge clk);
      packet <= p;
      req    <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!ack && n < HS_TIMEOUT);
      if (!ack) begin
         err_cnt++;
         $display("Timeout waiting for ack to rise in test %s", test_name);
      end
      req <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (ack && n < HS_TIMEOUT);
      if (ack) begin
         err_cnt++;
         $display("Timeout waiting for ack to fall in test %s", test_name);
      end
   endtask

   task automatic begin_test(input string name);
      test_name      = name;
      test_err_start = err_cnt;
      prev_valid     = 1'b0;                  // Fresh burst context
      burst_seen     = 1'b0;
   endtask

   // Waits for the lane to drain, then reports the test
   task automatic close_test();
      int n;
      n = 0;
      while ((exp_q.size() != 0 || tx_busy || lane_valid || ack) && n < DRAIN_TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (n >= DRAIN_TIMEOUT) begin
         err_cnt++;
         $display("Timeout in test %s, %0d words never came out", test_name, exp_q.size());
         exp_q.delete();
      end
      repeat (3) @(posedge clk);              // Last compare lands in this test
      if (err_cnt == test_err_start) begin
         tests_pass++;
         $display("Test %s: passed", test_name);
      end else begin
         tests_fail++;
         $display("Test %s: failed with %0d errors", test_name, err_cnt - test_err_start);
      end
   endtask

   //####################
   // Test sequence
   //####################
   initial begin
      logic [31:0] base;
      logic [31:0] rnd;
      seed            = 32'h435e_382a;
      err_cnt         = 0;
      tests_pass      = 0;
      tests_fail      = 0;
      nreset          = 1'b0;
      req             = 1'b0;
      packet          = '0;
      tx_enable       = 1'b0;
      burst_enable    = 1'b0;
      ctrlmode_bypass = 1'b0;
      ctrlmode        = 4'h0;
      lane_wait       = 1'b0;
      wait_rand       = 1'b0;
      hold_gate       = 1'b0;
      cyc             = '0;

      begin_test("reset");
      repeat (2) @(posedge clk);
      nreset    <= 1'b1;
      tx_enable <= 1'b1;
      close_test();

      begin_test("single");
      repeat (12) send_packet(random_packet());
      close_test();

      begin_test("override");
      @(posedge clk);
      rnd = $random(seed);
      ctrlmode_bypass <= 1'b1;
      ctrlmode        <= rnd[3:0];
      @(posedge clk);
      repeat (8) send_packet(random_packet());
      close_test();
      ctrlmode_bypass <= 1'b0;

      begin_test("burst_run");
      base = $random(seed) & 32'hffff_fff8;
      burst_enable <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < 6; i++) send_packet(make_packet(1'b1, DMODE_DOUBLE, 5'd0, base + 8 * i));
      burst_flag: assert (burst_seen) else begin
         err_cnt++;
         $display("tx_burst never went high during the burst run");
      end
      close_test();

      begin_test("burst_off");                // Same run, compression disabled
      burst_enable <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < 6; i++) send_packet(make_packet(1'b1, DMODE_DOUBLE, 5'd0, base + 8 * i));
      close_test();

      begin_test("burst_gap");                // Step of 16 breaks the run
      burst_enable <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < 6; i++) send_packet(make_packet(1'b1, DMODE_DOUBLE, 5'd0, base + 16 * i));
      close_test();

      begin_test("backpressure");
      for (int i = 0; i < 256; i++) wait_pat[i] = (($random(seed) & 3) == 0);
      wait_rand <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < 5; i++) send_packet(make_packet(1'b1, DMODE_DOUBLE, 5'd0, base + 8 * i));
      repeat (8) send_packet(random_packet());
      close_test();
      wait_rand    <= 1'b0;
      burst_enable <= 1'b0;

      begin_test("tx_enable");
      tx_enable <= 1'b0;
      @(posedge clk);
      send_packet(random_packet());
      fork
         send_packet(random_packet());
         begin
            hold_gate <= 1'b1;                // Second request stalls here
            repeat (16) @(posedge clk);
            hold_gate <= 1'b0;
            tx_enable <= 1'b1;
         end
      join
      close_test();

      $display("Tests passed: %0d, failed: %0d, check errors: %0d", tests_pass, tests_fail,
               err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
